//--- Bender.yml
package:
  name: err_report

export_include_dirs:
  - hw

sources:
  - hw/err_report_pkg.sv
  - hw/err_edge_status.sv
  - hw/err_arbiter.sv
  - hw/err_msg_ctrl.sv
  - hw/err_csr.sv
  - hw/err_report_top.sv
  - target: simulation
    files:
      - testbench/err_report_clkgen.sv
      - testbench/err_report_props.sv
      - testbench/err_report_tb.sv

//--- filelist.f
+incdir+hw
hw/err_report_pkg.sv
hw/err_edge_status.sv
hw/err_arbiter.sv
hw/err_msg_ctrl.sv
hw/err_csr.sv
hw/err_report_top.sv
testbench/err_report_clkgen.sv
testbench/err_report_props.sv
testbench/err_report_tb.sv

//--- hw/err_arbiter.sv
// Combinational pick of the next error to report, by severity class and then lowest source index
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_arbiter (
    // Sticky status of all sources
    input  err_report_pkg::err_word_u        err_status_vec,
    // Sources already reported
    input  logic [7:0]                       err_mask_vec,

    // Winner of this cycle
    output logic                             cand_valid,
    output logic [`ERR_IDX_W-1:0]            cand_src,
    output err_report_pkg::err_sev_e         cand_sev
);

    // First source index of each class
    localparam logic [`ERR_IDX_W-1:0] FATAL_BASE    = `ERR_IDX_W'(6);
    localparam logic [`ERR_IDX_W-1:0] NONFATAL_BASE = `ERR_IDX_W'(3);
    localparam logic [`ERR_IDX_W-1:0] CORR_BASE     = `ERR_IDX_W'(0);

    // Pending and not yet reported
    err_report_pkg::err_word_u elig;

    // ------------------------------------------------------------------------
    // Lowest set bit within a class of up to three sources
    // ------------------------------------------------------------------------

    function automatic logic [1:0] low_bit(input logic [2:0] vec);
        logic [1:0] pos;
        pos = 2'd0;
        // Scan downward so the lowest set bit is written last
        for (int k = 2; k >= 0; k--) begin
            if (vec[k]) begin
                pos = k[1:0];
            end
        end
        return pos;
    endfunction

    // ------------------------------------------------------------------------
    // Class priority
    // ------------------------------------------------------------------------

    always_comb begin
        elig.raw   = err_status_vec.raw & ~err_mask_vec;
        cand_valid = |elig.raw;
        cand_src   = '0;
        cand_sev   = err_report_pkg::sev_none;

        // Fatal first, then nonfatal, then correctable
        if (|elig.cls.fatal) begin
            cand_src = FATAL_BASE + `ERR_IDX_W'(low_bit({1'b0, elig.cls.fatal}));
            cand_sev = err_report_pkg::sev_fatal;
        end else if (|elig.cls.nonfatal) begin
            cand_src = NONFATAL_BASE + `ERR_IDX_W'(low_bit(elig.cls.nonfatal));
            cand_sev = err_report_pkg::sev_nonfatal;
        end else if (|elig.cls.corr) begin
            cand_src = CORR_BASE + `ERR_IDX_W'(low_bit(elig.cls.corr));
            cand_sev = err_report_pkg::sev_corr;
        end
    end

endmodule

`default_nettype wire

//--- hw/err_csr.sv
// Register side of the unit, with write-one-to-clear decode, status reads and the first-error log
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_csr (
    // Clock and reset
    input  logic                      prim_nonflr_clk,
    input  logic                      prim_gated_rst_b,

    // Software clear strobe and its write-one-to-clear data
    input  logic                      clr_valid,
    input  logic [7:0]                clr_data,
    // Sticky status of all sources
    input  err_report_pkg::err_word_u status_vec,
    // Message pulse watched for the log
    input  logic                      msg_valid,
    input  logic [`ERR_IDX_W-1:0]     msg_src,

    // Per-source clears
    output logic [7:0]                clr_err,
    // Read values
    output logic [7:0]                status_word,
    output logic                      fatal_any,
    output logic                      nonfatal_any,
    output logic                      corr_any,
    output logic [3:0]                first_err
);

    // Clear leaves no status bit set
    logic empty_clr;
    // Log waits for the next message
    logic armed;
    logic log_capture;

    // ------------------------------------------------------------------------
    // Clear decode and read path
    // ------------------------------------------------------------------------

    assign clr_err     = clr_valid ? clr_data : 8'b0;
    assign status_word = status_vec.raw;
    assign empty_clr   = clr_valid && ((status_vec.raw & ~clr_err) == 8'b0);

    // Class summaries
    assign fatal_any    = |status_vec.cls.fatal;
    assign nonfatal_any = |status_vec.cls.nonfatal;
    assign corr_any     = |status_vec.cls.corr;

    // ------------------------------------------------------------------------
    // First-error log
    // ------------------------------------------------------------------------

    assign log_capture = msg_valid && armed;

    // Value holds after rearm until the next message replaces it
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            armed     <= 1'b1;
            first_err <= `ERR_LOG_NONE;
        end else begin
            if (log_capture) begin
                first_err <= 4'(msg_src);
            end
            // An emptying clear rearms even if a message is captured on the same edge
            if (empty_clr) begin
                armed <= 1'b1;
            end else if (log_capture) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/err_edge_status.sv
// Per-source rising-edge detect with sticky status and arbitration mask, instantiated once per error
`timescale 1ns/1ps
`default_nettype none

module err_edge_status (
    // Clock and reset
    input  logic prim_nonflr_clk,
    input  logic prim_gated_rst_b,

    // Error level, software clear and take strobe from the message control
    input  logic err_signal,
    input  logic clr_err,
    input  logic err_taken,

    // Blocks the source from arbitration once its message went out
    output logic err_arb_mask,
    // Sticky status, set on a rising edge of the error level
    output logic err_status
);

    // Level seen on the previous edge
    logic err_signal_q;
    // Rising edge that is not cancelled by a clear
    logic rise_set;

    // ------------------------------------------------------------------------
    // Edge detect
    // ------------------------------------------------------------------------

    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            err_signal_q <= 1'b0;
        end else begin
            err_signal_q <= err_signal;
        end
    end

    // A clear on the same edge cancels the rise
    assign rise_set = err_signal && !err_signal_q && !clr_err;

    // ------------------------------------------------------------------------
    // Sticky status
    // ------------------------------------------------------------------------

    // Clear has priority over set
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            err_status <= 1'b0;
        end else if (clr_err) begin
            err_status <= 1'b0;
        end else if (rise_set) begin
            err_status <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Arbitration mask
    // ------------------------------------------------------------------------

    // A take in the clear cycle keeps the mask set
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            err_arb_mask <= 1'b0;
        end else if (err_taken) begin
            err_arb_mask <= 1'b1;
        end else if (clr_err) begin
            err_arb_mask <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/err_msg_ctrl.sv
// Message issue control, registers the arbiter winner into a one-cycle pulse and enforces the gap
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_msg_ctrl (
    // Clock and reset
    input  logic                     prim_nonflr_clk,
    input  logic                     prim_gated_rst_b,

    // Candidate from the arbiter
    input  logic                     cand_valid,
    input  logic [`ERR_IDX_W-1:0]    cand_src,
    input  err_report_pkg::err_sev_e cand_sev,

    // Message pulse and its payload
    output logic                     msg_valid,
    output logic [`ERR_IDX_W-1:0]    msg_src,
    output err_report_pkg::err_sev_e msg_sev,
    // Take strobe, one bit per source
    output logic [7:0]               take_onehot
);

    // Gap counter must hold the full gap length
    localparam int CNT_W = $clog2(`ERR_MSG_GAP + 1);

    // FSM encoding
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_GAP  = 1'b1;

    logic             state;
    logic [CNT_W-1:0] gap_cnt;
    // Candidate is registered this edge
    logic             accept;

    assign accept = (state == ST_IDLE) && cand_valid;

    // ------------------------------------------------------------------------
    // Idle and gap FSM
    // ------------------------------------------------------------------------

    // Leaving gap when the count reaches one gives ERR_MSG_GAP quiet cycles
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            state   <= ST_IDLE;
            gap_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_GAP;
                        gap_cnt <= CNT_W'(`ERR_MSG_GAP);
                    end
                end
                ST_GAP: begin
                    if (gap_cnt == CNT_W'(1)) begin
                        state   <= ST_IDLE;
                        gap_cnt <= '0;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    gap_cnt <= '0;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Message pulse and take strobe
    // ------------------------------------------------------------------------

    // Both fall again on the next edge
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            msg_valid   <= 1'b0;
            take_onehot <= '0;
        end else begin
            msg_valid   <= accept;
            take_onehot <= accept ? (8'b1 << cand_src) : 8'b0;
        end
    end

    // Payload only qualified by msg_valid
    always_ff @(posedge prim_nonflr_clk) begin
        if (accept) begin
            msg_src <= cand_src;
            msg_sev <= cand_sev;
        end
    end

endmodule

`default_nettype wire

//--- hw/err_report_pkg.sv
// Shared types of the error reporting unit, referenced by package scope from RTL and testbench
`default_nettype none

package err_report_pkg;

    // -----------------------------------------------------------------------
    // Severity of a reported error
    // -----------------------------------------------------------------------

    // Encoding ranks severity so a larger value is more severe
    typedef enum logic [1:0] {
        sev_none     = 2'd0,
        sev_corr     = 2'd1,
        sev_nonfatal = 2'd2,
        sev_fatal    = 2'd3
    } err_sev_e;

    // -----------------------------------------------------------------------
    // Status word, one bit per source
    // -----------------------------------------------------------------------

    // Raw view for register reads and clears
    // Class view for arbitration and summaries
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] fatal;      // Sources 7 and 6
            logic [2:0] nonfatal;   // Sources 5 to 3
            logic [2:0] corr;       // Sources 2 to 0
        } cls;
    } err_word_u;

endpackage

`default_nettype wire

//--- hw/err_report_settings.svh
// Fixed constants of the error reporting unit, included by each RTL file that sizes or times on them
`ifndef ERR_REPORT_SETTINGS_SVH
`define ERR_REPORT_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Source layout
// ---------------------------------------------------------------------------

// Number of error sources, fixed by the status word layout
`define ERR_NUM 8

// Width of a source index
`define ERR_IDX_W 3

// ---------------------------------------------------------------------------
// Timing and log encodings
// ---------------------------------------------------------------------------

// Idle cycles forced after each message pulse
`define ERR_MSG_GAP 4

// First-error log value meaning nothing logged yet
`define ERR_LOG_NONE 4'd8

`endif

//--- hw/err_report_top.sv
// Top level of the error reporting unit, wiring per-source status, arbiter, control and CSR blocks
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_report_top (
    // Clock and reset
    input  wire                       prim_nonflr_clk,
    input  wire                       prim_gated_rst_b,

    // Error levels
    input  wire [`ERR_NUM-1:0]        err_in,
    // Software clear
    input  wire                       clr_valid,
    input  wire [`ERR_NUM-1:0]        clr_data,

    // Message pulse
    output logic                      msg_valid,
    output logic [`ERR_IDX_W-1:0]     msg_src,
    output err_report_pkg::err_sev_e  msg_sev,

    // Register reads
    output logic [`ERR_NUM-1:0]       status_word,
    output logic                      fatal_any,
    output logic                      nonfatal_any,
    output logic                      corr_any,
    output logic [3:0]                first_err
);

    // Per-source nets, one driver bit each
    wire [`ERR_NUM-1:0] clr_err;
    wire [`ERR_NUM-1:0] err_status;
    wire [`ERR_NUM-1:0] err_arb_mask;
    wire [`ERR_NUM-1:0] take_onehot;

    // Arbiter winner
    logic                     cand_valid;
    logic [`ERR_IDX_W-1:0]    cand_src;
    err_report_pkg::err_sev_e cand_sev;

    // ------------------------------------------------------------------------
    // Per-source edge detect and status
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < `ERR_NUM; i++) begin : g_src
        err_edge_status u_stat (
            .prim_nonflr_clk  (prim_nonflr_clk),
            .prim_gated_rst_b (prim_gated_rst_b),
            .err_signal       (err_in[i]),
            .clr_err          (clr_err[i]),
            .err_taken        (take_onehot[i]),
            .err_arb_mask     (err_arb_mask[i]),
            .err_status       (err_status[i])
        );
    end

    // ------------------------------------------------------------------------
    // Arbitration, message control and registers
    // ------------------------------------------------------------------------

    err_arbiter u_arb (
        .err_status_vec (err_status),
        .err_mask_vec   (err_arb_mask),
        .cand_valid     (cand_valid),
        .cand_src       (cand_src),
        .cand_sev       (cand_sev)
    );

    err_msg_ctrl u_ctrl (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b),
        .cand_valid       (cand_valid),
        .cand_src         (cand_src),
        .cand_sev         (cand_sev),
        .msg_valid        (msg_valid),
        .msg_src          (msg_src),
        .msg_sev          (msg_sev),
        .take_onehot      (take_onehot)
    );

    // Log watches the same pulse that leaves the top
    err_csr u_csr (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b),
        .clr_valid        (clr_valid),
        .clr_data         (clr_data),
        .status_vec       (err_status),
        .msg_valid        (msg_valid),
        .msg_src          (msg_src),
        .clr_err          (clr_err),
        .status_word      (status_word),
        .fatal_any        (fatal_any),
        .nonfatal_any     (nonfatal_any),
        .corr_any         (corr_any),
        .first_err        (first_err)
    );

endmodule

`default_nettype wire

//--- testbench/err_report_clkgen.sv
// Testbench clock and reset source, 8 ns clock with reset held low for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module err_report_clkgen (
    output logic prim_nonflr_clk,
    output logic prim_gated_rst_b
);

    // Free-running clock, 8 ns period
    initial begin
        prim_nonflr_clk = 1'b0;
        forever #4 prim_nonflr_clk = ~prim_nonflr_clk;
    end

    // Release just after an edge so no flop sees it at the edge itself
    initial begin
        prim_gated_rst_b = 1'b0;
        repeat (10) @(posedge prim_nonflr_clk);
        #1 prim_gated_rst_b = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/err_report_golden.txt
// id  rise  clr_rise  status  clr_after  status_after  first_err   (all hex)
// Vectors run in order and status carries over from one to the next
01 10 00 10 00 10 4
02 C9 00 D9 41 98 4
03 41 00 D9 FF 00 4
04 24 04 20 20 00 5
05 06 00 06 02 04 1
06 80 00 84 FF 00 1
07 FF 00 FF FF 00 6
08 08 08 00 00 00 6

//--- testbench/err_report_props.sv
// Concurrent checks on the message pulse, gap and take strobe, bound into the top level
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_report_props (
    input logic                  prim_nonflr_clk,
    input logic                  prim_gated_rst_b,
    input logic                  msg_valid,
    input logic [`ERR_IDX_W-1:0] msg_src,
    input logic [7:0]            take_onehot,
    input logic [7:0]            clr_err
);

    // Sources reported and not cleared since
    logic [7:0] reported;

    // A take on the clear edge keeps the source marked, as the mask does
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            reported <= '0;
        end else begin
            reported <= (reported & ~clr_err) | take_onehot;
        end
    end

    // ------------------------------------------------------------------------
    // Pulse shape and spacing
    // ------------------------------------------------------------------------

    single_pulse: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        msg_valid |=> !msg_valid)
        else $error("msg_valid high on two cycles in a row");

    gap_quiet: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        msg_valid |=> !msg_valid [*`ERR_MSG_GAP])
        else $error("message issued inside the gap");

    // ------------------------------------------------------------------------
    // Take strobe and repeat check
    // ------------------------------------------------------------------------

    // The take must name the same source as the message
    take_shape: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        msg_valid ? (take_onehot == (8'b1 << msg_src)) : (take_onehot == 8'b0))
        else $error("take_onehot does not match msg_src with msg_valid or not zero without it");

    no_repeat: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
        msg_valid |-> !reported[msg_src])
        else $error("source reported again without a clear in between");

endmodule

bind err_report_top err_report_props u_props (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .msg_valid        (msg_valid),
    .msg_src          (msg_src),
    .take_onehot      (take_onehot),
    .clr_err          (clr_err)
);

`default_nettype wire

//--- testbench/err_report_tb.sv
// Testbench top, replays the golden vectors against the error reporting unit and checks the results
`timescale 1ns/1ps
`default_nettype none

`include "err_report_settings.svh"

module err_report_tb;

    localparam int NUM_TESTS = 8;
    localparam int COLS      = 7;
    // Budget of 40 cycles per vector plus reset
    localparam int CYC_LIMIT = NUM_TESTS * 40 + 10;

    wire                      prim_nonflr_clk;
    wire                      prim_gated_rst_b;
    logic [`ERR_NUM-1:0]      err_in;
    logic                     clr_valid;
    logic [`ERR_NUM-1:0]      clr_data;
    logic                     msg_valid;
    logic [`ERR_IDX_W-1:0]    msg_src;
    err_report_pkg::err_sev_e msg_sev;
    logic [`ERR_NUM-1:0]      status_word;
    logic                     fatal_any;
    logic                     nonfatal_any;
    logic                     corr_any;
    logic [3:0]               first_err;

    // Columns: id, rise pattern, clear with rise, status, clear after, status after, first
    logic [31:0] gold [0:NUM_TESTS*COLS-1];
    int          cyc = 0;
    int          got_src[$];
    int          got_sev[$];
    int          got_cyc[$];
    int          errors;
    int          test_errs;
    int          tests_run;
    logic [31:0] rng;
    logic [7:0]  prev_status;

    err_report_clkgen u_clk (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b)
    );

    err_report_top dut0 (
        .prim_nonflr_clk  (prim_nonflr_clk),
        .prim_gated_rst_b (prim_gated_rst_b),
        .err_in           (err_in),
        .clr_valid        (clr_valid),
        .clr_data         (clr_data),
        .msg_valid        (msg_valid),
        .msg_src          (msg_src),
        .msg_sev          (msg_sev),
        .status_word      (status_word),
        .fatal_any        (fatal_any),
        .nonfatal_any     (nonfatal_any),
        .corr_any         (corr_any),
        .first_err        (first_err)
    );

    // ------------------------------------------------------------------------
    // Cycle count, message capture and run limit
    // ------------------------------------------------------------------------

    always @(posedge prim_nonflr_clk) begin
        cyc <= cyc + 1;
    end

    // Outputs are stable at the falling edge
    always @(negedge prim_nonflr_clk) begin
        if (prim_gated_rst_b && msg_valid) begin
            got_src.push_back(int'(msg_src));
            got_sev.push_back(int'(msg_sev));
            got_cyc.push_back(cyc);
        end
    end

    always @(posedge prim_nonflr_clk) begin
        if (cyc >= CYC_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached before the tests ended", CYC_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Class of a source from the status word layout
    function automatic int sev_of(input int idx);
        if (idx >= 6) begin
            return 3;
        end else if (idx >= 3) begin
            return 2;
        end
        return 1;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        errors++;
        test_errs++;
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge prim_nonflr_clk);
        #1;
    endtask

    task automatic check_reads(input logic [7:0] exp_stat);
        if (status_word !== exp_stat) begin
            report_mismatch("status_word", status_word, exp_stat);
        end
        if (fatal_any !== (|exp_stat[7:6])) begin
            report_mismatch("fatal_any", fatal_any, |exp_stat[7:6]);
        end
        if (nonfatal_any !== (|exp_stat[5:3])) begin
            report_mismatch("nonfatal_any", nonfatal_any, |exp_stat[5:3]);
        end
        if (corr_any !== (|exp_stat[2:0])) begin
            report_mismatch("corr_any", corr_any, |exp_stat[2:0]);
        end
    endtask

    // ------------------------------------------------------------------------
    // One golden vector
    // ------------------------------------------------------------------------

    task automatic run_vector(input int t);
        int         id;
        logic [7:0] pattern;
        logic [7:0] clr_rise;
        logic [7:0] exp_stat;
        logic [7:0] clr_after;
        logic [7:0] exp_after;
        logic [3:0] exp_first;
        logic [7:0] new_bits;
        int         exp_src[$];
        int         waited;
        int         n;
        id        = int'(gold[t*COLS]);
        pattern   = gold[t*COLS+1][7:0];
        clr_rise  = gold[t*COLS+2][7:0];
        exp_stat  = gold[t*COLS+3][7:0];
        clr_after = gold[t*COLS+4][7:0];
        exp_after = gold[t*COLS+5][7:0];
        exp_first = gold[t*COLS+6][3:0];
        test_errs = 0;
        got_src.delete();
        got_sev.delete();
        got_cyc.delete();

        // Fatal, then nonfatal, then correctable, lowest index first
        new_bits = pattern & ~clr_rise & ~prev_status;
        for (int s = 3; s >= 1; s--) begin
            for (int i = 0; i < `ERR_NUM; i++) begin
                if (new_bits[i] && sev_of(i) == s) begin
                    exp_src.push_back(i);
                end
            end
        end

        next_cycle();
        err_in    = pattern;
        clr_valid = (clr_rise != 8'h00);
        clr_data  = clr_rise;
        next_cycle();
        clr_valid = 1'b0;
        clr_data  = '0;

        waited = 0;
        while (got_src.size() < exp_src.size() && waited < 8 * (`ERR_MSG_GAP + 1) + 4) begin
            next_cycle();
            waited++;
        end
        if (got_src.size() < exp_src.size()) begin
            $display("Fail at %0d ns: test %0d timed out waiting for message %0d",
                     $time, id, got_src.size());
            errors++;
            test_errs++;
        end
        // Let a stray extra message show up
        repeat (`ERR_MSG_GAP + 2) next_cycle();
        if (got_src.size() != exp_src.size()) begin
            report_mismatch("message count", got_src.size(), exp_src.size());
        end

        n = (got_src.size() < exp_src.size()) ? got_src.size() : exp_src.size();
        for (int m = 0; m < n; m++) begin
            if (got_src[m] != exp_src[m]) begin
                report_mismatch($sformatf("message %0d source", m), got_src[m], exp_src[m]);
            end
            if (got_sev[m] != sev_of(exp_src[m])) begin
                report_mismatch($sformatf("message %0d severity", m), got_sev[m],
                                sev_of(exp_src[m]));
            end
            if (m > 0 && got_cyc[m] - got_cyc[m-1] < `ERR_MSG_GAP + 1) begin
                report_mismatch($sformatf("message %0d spacing", m),
                                got_cyc[m] - got_cyc[m-1], `ERR_MSG_GAP + 1);
            end
        end
        check_reads(exp_stat);
        if (first_err !== exp_first) begin
            report_mismatch("first_err", first_err, exp_first);
        end

        // Toggle already reported sources, which must stay silent
        n = got_src.size();
        for (int k = 0; k < 6; k++) begin
            next_cycle();
            rng    = xorshift(rng);
            err_in = rng[7:0] & exp_stat;
        end
        next_cycle();
        err_in = '0;
        repeat (2) next_cycle();
        if (got_src.size() != n) begin
            report_mismatch("messages from held sources", got_src.size() - n, 0);
        end

        // Write-one-to-clear
        clr_valid = (clr_after != 8'h00);
        clr_data  = clr_after;
        next_cycle();
        clr_valid = 1'b0;
        clr_data  = '0;
        check_reads(exp_after);
        prev_status = exp_after;

        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d: ok", id);
        end else begin
            $display("test %0d: %0d errors", id, test_errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        errors      = 0;
        tests_run   = 0;
        rng         = 32'd16;
        prev_status = 8'h00;
        err_in      = '0;
        clr_valid   = 1'b0;
        clr_data    = '0;
        $readmemh("testbench/err_report_golden.txt", gold);

        @(posedge prim_gated_rst_b);
        next_cycle();
        // Empty log reads 8 after reset
        if (first_err !== 4'd8) begin
            report_mismatch("first_err after reset", first_err, 8);
        end
        check_reads(8'h00);

        if (gold[0] === 'x) begin
            $display("Golden file could not be read");
            errors++;
        end else begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_vector(t);
            end
        end

        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
